// File: rs_dist.f
rtl/dist_cfg_pkg.sv
rtl/dist_types_pkg.sv
rtl/rsp_receiver.sv
rtl/we_receiver.sv
rtl/opd_dispatcher.sv
rtl/opd_emitter.sv
rtl/rs_dist_top.sv
verification/rs_dist_asserts.sv
verification/rs_dist_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = rs_dist_tb
FILELIST = rs_dist.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJDIR)

// File: verification/rs_dist_tb.sv
/*
 * directed testbench for the response distributor:
 * clock, reset, source and sink models, tests and timeout
 */
`timescale 1ns/1ps
`default_nettype none

module rs_dist_tb;

	// per-test wait limits add up to well under this
	localparam int CYCLE_LIMIT = 5000;

	logic clk;
	logic nrst;
	logic i_rrs_vld;
	dist_types_pkg::rsp_t i_rrs;
	logic o_rrs_rd;
	dist_types_pkg::we_in_t [dist_cfg_pkg::NUM_CH-1:0] i_we;
	logic [dist_cfg_pkg::NUM_CH-1:0] o_we_rd;
	dist_types_pkg::opd_out_t [dist_cfg_pkg::NUM_CH-1:0] o_opd;
	logic [dist_cfg_pkg::NUM_CH-1:0] i_opd_rdy;
	logic i_err_flush;
	logic o_busy;

	// source models and expected operands per channel
	dist_types_pkg::rsp_t rsp_src[$];
	dist_types_pkg::wmask_t we_src[dist_cfg_pkg::NUM_CH][$];
	dist_types_pkg::opd_t exp_q[dist_cfg_pkg::NUM_CH][$];

	int cycles = 0;
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	string test_name;
	logic rsp_taken;
	logic rd_low_seen;

	rs_dist_top DUT (
		.clk(clk),
		.nrst(nrst),
		.i_rrs_vld(i_rrs_vld),
		.i_rrs(i_rrs),
		.o_rrs_rd(o_rrs_rd),
		.i_we(i_we),
		.o_we_rd(o_we_rd),
		.o_opd(o_opd),
		.i_opd_rdy(i_opd_rdy),
		.i_err_flush(i_err_flush),
		.o_busy(o_busy)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// channel is 2*thread + argument
	function automatic dist_types_pkg::rsp_t make_rsp(input int ch,
		input dist_types_pkg::data_t d);
		dist_types_pkg::rsp_t r;
		r.thread = dist_types_pkg::thread_t'(ch / 2);
		r.arg = (ch % 2) != 0;
		r.data = d;
		return r;
	endfunction

	function automatic dist_types_pkg::data_t rand_data();
		return {$urandom, $urandom};
	endfunction

	function automatic dist_types_pkg::wmask_t rand_mask();
		return dist_types_pkg::wmask_t'($urandom_range(3, 1));
	endfunction

	task automatic queue_all(input int ch, input dist_types_pkg::data_t d,
		input dist_types_pkg::wmask_t m, input logic with_rsp, input logic with_mask);
		dist_types_pkg::opd_t e;
		e.data = d;
		e.mask = m;
		if (with_mask)
			we_src[ch].push_back(m);
		if (with_rsp)
			rsp_src.push_back(make_rsp(ch, d));
		if (with_rsp && with_mask)
			exp_q[ch].push_back(e);
	endtask

	task automatic check_output(input int ch);
		dist_types_pkg::opd_t e;
		if (exp_q[ch].size() == 0)
		begin
			$display("%s: unexpected operand on channel %0d, data %h wr %b",
				test_name, ch, o_opd[ch].data, o_opd[ch].wr);
			test_errors++;
		end
		else
		begin
			e = exp_q[ch].pop_front();
			if (o_opd[ch].data !== e.data || o_opd[ch].wr !== e.mask)
			begin
				$display("ERROR %s: channel %0d expected %h/%b, actual %h/%b", test_name,
					ch, e.data, e.mask, o_opd[ch].data, o_opd[ch].wr);
				test_errors++;
			end
		end
	endtask

	// one clock of driving, sampling at negedge and advancing the sources
	task automatic step();
		logic take_rsp;
		logic [dist_cfg_pkg::NUM_CH-1:0] take_we;
		i_rrs_vld = (rsp_src.size() != 0);
		if (rsp_src.size() != 0)
			i_rrs = rsp_src[0];
		for (int ch = 0; ch < dist_cfg_pkg::NUM_CH; ch++)
		begin
			i_we[ch].vld = (we_src[ch].size() != 0);
			if (we_src[ch].size() != 0)
				i_we[ch].mask = we_src[ch][0];
		end
		@(negedge clk);
		take_rsp = i_rrs_vld && o_rrs_rd;
		if (rsp_taken && i_rrs_vld && !o_rrs_rd)
			rd_low_seen = 1'b1;
		for (int ch = 0; ch < dist_cfg_pkg::NUM_CH; ch++)
		begin
			take_we[ch] = i_we[ch].vld && o_we_rd[ch];
			if (o_opd[ch].wr != '0 && i_opd_rdy[ch])
				check_output(ch);
		end
		@(posedge clk);
		#1;
		if (take_rsp)
		begin
			void'(rsp_src.pop_front());
			rsp_taken = 1'b1;
		end
		for (int ch = 0; ch < dist_cfg_pkg::NUM_CH; ch++)
		begin
			if (take_we[ch])
				void'(we_src[ch].pop_front());
		end
	endtask

	function automatic logic done(input logic need_idle);
		logic d;
		d = (rsp_src.size() == 0);
		for (int ch = 0; ch < dist_cfg_pkg::NUM_CH; ch++)
		begin
			d = d && (we_src[ch].size() == 0);
			if (need_idle)
				d = d && (exp_q[ch].size() == 0);
		end
		if (need_idle)
			d = d && !o_busy;
		return d;
	endfunction

	// waits for all sources taken and with need_idle for a drained DUT
	task automatic wait_for(input logic need_idle, input int limit);
		int n;
		n = 0;
		while (!done(need_idle) && n < limit)
		begin
			step();
			n++;
		end
		if (!done(need_idle))
		begin
			$display("%s: DUT did not %s within %0d cycles", test_name,
				need_idle ? "drain" : "take all inputs", limit);
			test_errors++;
		end
	endtask

	task automatic pulse_flush();
		i_err_flush = 1'b1;
		step();
		i_err_flush = 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
		rsp_taken = 1'b0;
		rd_low_seen = 1'b0;
	endtask

	// idle check closes every test
	task automatic finish_test();
		if (o_busy !== 1'b0)
		begin
			$display("ERROR %s: o_busy expected 0, actual %b", test_name, o_busy);
			test_errors++;
		end
		if (o_rrs_rd !== 1'b0)
		begin
			$display("ERROR %s: o_rrs_rd expected 0, actual %b", test_name, o_rrs_rd);
			test_errors++;
		end
		if (o_we_rd !== '0)
		begin
			$display("ERROR %s: o_we_rd expected %h, actual %h", test_name,
				{dist_cfg_pkg::NUM_CH{1'b0}}, o_we_rd);
			test_errors++;
		end
		for (int ch = 0; ch < dist_cfg_pkg::NUM_CH; ch++)
		begin
			if (o_opd[ch].wr !== '0)
			begin
				$display("ERROR %s: channel %0d wr expected 00, actual %b", test_name,
					ch, o_opd[ch].wr);
				test_errors++;
			end
		end
		tests_run++;
		errors += test_errors;
		if (test_errors == 0)
			$display("%s: pass", test_name);
		else
		begin
			tests_failed++;
			$display("%s: fail with %0d errors", test_name, test_errors);
		end
	endtask

	task automatic test_reset_idle();
		start_test("reset_idle");
		finish_test();
	endtask

	task automatic test_single_route();
		int ch;
		dist_types_pkg::data_t d;
		dist_types_pkg::wmask_t m;
		start_test("single_route");
		ch = int'($urandom_range(dist_cfg_pkg::NUM_CH - 1, 0));
		d = rand_data();
		m = rand_mask();
		// mask goes in first
		queue_all(ch, d, m, 1'b0, 1'b1);
		wait_for(1'b0, 50);
		queue_all(ch, d, m, 1'b1, 1'b1);
		we_src[ch].delete();
		wait_for(1'b1, 200);
		finish_test();
	endtask

	task automatic test_channel_order();
		int ch;
		start_test("channel_order");
		for (int i = 0; i < 12; i++)
		begin
			ch = int'($urandom_range(dist_cfg_pkg::NUM_CH - 1, 0));
			queue_all(ch, rand_data(), rand_mask(), 1'b1, 1'b1);
		end
		wait_for(1'b1, 600);
		finish_test();
	endtask

	task automatic test_mask_wait();
		int ch;
		dist_types_pkg::data_t d;
		dist_types_pkg::wmask_t m;
		dist_types_pkg::opd_t e;
		start_test("mask_wait");
		ch = int'($urandom_range(dist_cfg_pkg::NUM_CH - 1, 0));
		d = rand_data();
		m = rand_mask();
		queue_all(ch, d, m, 1'b1, 1'b0);
		wait_for(1'b0, 50);
		repeat (20) step();
		if (!o_busy)
		begin
			$display("%s: o_busy low while a response waits for its mask", test_name);
			test_errors++;
		end
		queue_all(ch, d, m, 1'b0, 1'b1);
		e.data = d;
		e.mask = m;
		exp_q[ch].push_back(e);
		wait_for(1'b1, 200);
		finish_test();
	endtask

	task automatic test_back_pressure();
		int ch;
		int n;
		start_test("back_pressure");
		ch = int'($urandom_range(dist_cfg_pkg::NUM_CH - 1, 0));
		i_opd_rdy[ch] = 1'b0;
		for (int i = 0; i < 16; i++)
			queue_all(ch, rand_data(), rand_mask(), 1'b1, 1'b1);
		n = 0;
		while (!rd_low_seen && n < 80)
		begin
			step();
			n++;
		end
		if (!rd_low_seen)
		begin
			$display("%s: o_rrs_rd never dropped with the channel held", test_name);
			test_errors++;
		end
		i_opd_rdy[ch] = 1'b1;
		wait_for(1'b1, 600);
		finish_test();
	endtask

	task automatic test_error_flush();
		int chs[3];
		dist_types_pkg::data_t d;
		dist_types_pkg::wmask_t m;
		start_test("error_flush");
		chs[0] = int'($urandom_range(dist_cfg_pkg::NUM_CH - 1, 0));
		chs[1] = (chs[0] + 5) % dist_cfg_pkg::NUM_CH;
		chs[2] = (chs[0] + 11) % dist_cfg_pkg::NUM_CH;
		for (int i = 0; i < 3; i++)
			queue_all(chs[i], rand_data(), rand_mask(), 1'b1, 1'b0);
		wait_for(1'b0, 50);
		repeat (2) step();
		pulse_flush();
		wait_for(1'b1, 100);
		// late masks find nothing to pair with
		for (int i = 0; i < 3; i++)
			queue_all(chs[i], '0, rand_mask(), 1'b0, 1'b1);
		wait_for(1'b0, 50);
		repeat (10) step();
		// drop the stale masks before the fresh transfer
		pulse_flush();
		wait_for(1'b1, 100);
		d = rand_data();
		m = rand_mask();
		queue_all(chs[0], d, m, 1'b1, 1'b1);
		wait_for(1'b1, 200);
		finish_test();
	endtask

	initial
	begin
		// fixed seed for data values and channels
		void'($urandom(95895));
		clk = 1'b0;
		nrst = 1'b0;
		i_rrs_vld = 1'b0;
		i_rrs = '0;
		i_we = '0;
		i_opd_rdy = '1;
		i_err_flush = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		nrst = 1'b1;
		test_reset_idle();
		test_single_route();
		test_channel_order();
		test_mask_wait();
		test_back_pressure();
		test_error_flush();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/rs_dist_asserts.sv
/*
 * concurrent checks on the distributor top level:
 * held operands, read strobe after reset, busy during output
 */
`timescale 1ns/1ps
`default_nettype none

module rs_dist_asserts (
	input wire logic clk,
	input wire logic nrst,
	input wire logic o_rrs_rd,
	input wire dist_types_pkg::opd_out_t [dist_cfg_pkg::NUM_CH-1:0] o_opd,
	input wire logic [dist_cfg_pkg::NUM_CH-1:0] i_opd_rdy,
	input wire logic o_busy
);

	logic [dist_cfg_pkg::NUM_CH-1:0] wr_on;

	always_comb
	begin
		for (int ch = 0; ch < dist_cfg_pkg::NUM_CH; ch++)
			wr_on[ch] = (o_opd[ch].wr != '0);
	end

	// presented operand holds until taken
	for (genvar ch = 0; ch < dist_cfg_pkg::NUM_CH; ch++)
	begin : g_hold
		a_hold: assert property (@(posedge clk) disable iff (!nrst)
			(wr_on[ch] && !i_opd_rdy[ch]) |=> $stable(o_opd[ch]))
			else $error("channel %0d operand changed while not ready", ch);
	end

	a_rd_after_reset: assert property (@(posedge clk) $rose(nrst) |-> !o_rrs_rd)
		else $error("o_rrs_rd high in the first cycle after reset");

	a_busy: assert property (@(posedge clk) disable iff (!nrst) (|wr_on) |-> o_busy)
		else $error("o_busy low while an operand is presented");

endmodule

bind rs_dist_top rs_dist_asserts u_asserts (
	.clk(clk),
	.nrst(nrst),
	.o_rrs_rd(o_rrs_rd),
	.o_opd(o_opd),
	.i_opd_rdy(i_opd_rdy),
	.o_busy(o_busy)
);

`default_nettype wire

// File: rtl/rs_dist_top.sv
/*
 * response distributor top level: response receiver,
 * per-channel mask receivers, dispatcher and operand emitters
 */
`timescale 1ns/1ps
`default_nettype none

module rs_dist_top (
	input wire logic clk,
	input wire logic nrst,
	// load/store unit
	input wire logic i_rrs_vld,
	input wire dist_types_pkg::rsp_t i_rrs,
	output logic o_rrs_rd,
	// word-enable sources
	input wire dist_types_pkg::we_in_t [dist_cfg_pkg::NUM_CH-1:0] i_we,
	output logic [dist_cfg_pkg::NUM_CH-1:0] o_we_rd,
	// operand register file
	output dist_types_pkg::opd_out_t [dist_cfg_pkg::NUM_CH-1:0] o_opd,
	input wire logic [dist_cfg_pkg::NUM_CH-1:0] i_opd_rdy,
	// control
	input wire logic i_err_flush,
	output logic o_busy
);

	dist_types_pkg::rsp_t rsp_head;
	logic rsp_empty;
	logic rsp_busy;
	logic rsp_pop;
	logic flush;
	dist_types_pkg::wmask_t [dist_cfg_pkg::NUM_CH-1:0] we_head;
	logic [dist_cfg_pkg::NUM_CH-1:0] we_empty;
	logic [dist_cfg_pkg::NUM_CH-1:0] we_busy;
	logic [dist_cfg_pkg::NUM_CH-1:0] we_pop;
	logic [dist_cfg_pkg::NUM_CH-1:0] opd_stall;
	logic [dist_cfg_pkg::NUM_CH-1:0] opd_busy;
	logic [dist_cfg_pkg::NUM_CH-1:0] push;
	dist_types_pkg::opd_t push_opd;

	rsp_receiver u_rsp_rx (
		.clk(clk),
		.nrst(nrst),
		.i_rrs_vld(i_rrs_vld),
		.i_rrs(i_rrs),
		.o_rrs_rd(o_rrs_rd),
		.i_pop(rsp_pop),
		.i_flush(flush),
		.o_head(rsp_head),
		.o_empty(rsp_empty),
		.o_busy(rsp_busy)
	);

	// one mask receiver and one emitter per channel
	for (genvar ch = 0; ch < dist_cfg_pkg::NUM_CH; ch++)
	begin : g_ch
		we_receiver u_we_rx (
			.clk(clk),
			.nrst(nrst),
			.i_we(i_we[ch]),
			.o_we_rd(o_we_rd[ch]),
			.i_pop(we_pop[ch]),
			.i_flush(flush),
			.o_head(we_head[ch]),
			.o_empty(we_empty[ch]),
			.o_busy(we_busy[ch])
		);

		opd_emitter u_emit (
			.clk(clk),
			.nrst(nrst),
			.i_push(push[ch]),
			.i_opd(push_opd),
			.o_stall(opd_stall[ch]),
			.o_busy(opd_busy[ch]),
			.o_opd(o_opd[ch]),
			.i_opd_rdy(i_opd_rdy[ch])
		);
	end

	opd_dispatcher u_disp (
		.clk(clk),
		.nrst(nrst),
		.i_err_flush(i_err_flush),
		.i_rsp_head(rsp_head),
		.i_rsp_empty(rsp_empty),
		.i_rsp_busy(rsp_busy),
		.o_rsp_pop(rsp_pop),
		.i_we_head(we_head),
		.i_we_empty(we_empty),
		.i_we_busy(we_busy),
		.o_we_pop(we_pop),
		.i_opd_stall(opd_stall),
		.i_opd_busy(opd_busy),
		.o_push(push),
		.o_push_opd(push_opd),
		.o_flush(flush),
		.o_busy(o_busy)
	);

endmodule

`default_nettype wire

// File: rtl/opd_emitter.sv
/*
 * operand queue and output FSM for one channel,
 * output held until the register file is ready
 */
`timescale 1ns/1ps
`default_nettype none

module opd_emitter (
	input wire logic clk,
	input wire logic nrst,
	input wire logic i_push,
	input wire dist_types_pkg::opd_t i_opd,
	output logic o_stall,
	output logic o_busy,
	output dist_types_pkg::opd_out_t o_opd,
	input wire logic i_opd_rdy
);

	dist_types_pkg::opd_t mem [2**dist_cfg_pkg::OPD_DEPTH_LOG2];

	logic [dist_cfg_pkg::OPD_DEPTH_LOG2:0] wp;
	logic [dist_cfg_pkg::OPD_DEPTH_LOG2:0] rp;
	logic [dist_cfg_pkg::OPD_DEPTH_LOG2:0] used;
	logic empty;
	logic load;
	dist_types_pkg::opd_t head;
	dist_types_pkg::data_t out_data;
	dist_types_pkg::wmask_t out_wr;
	dist_types_pkg::emit_state_t state;

	assign used = wp - rp;
	assign empty = (wp == rp);
	assign head = mem[rp[dist_cfg_pkg::OPD_DEPTH_LOG2-1:0]];

	assign o_stall = used[dist_cfg_pkg::OPD_DEPTH_LOG2] ||
		(&used[dist_cfg_pkg::OPD_DEPTH_LOG2-1:0]);
	assign o_busy = (state != dist_types_pkg::EMIT_IDLE) || !empty;

	// next entry goes out when idle, or when the current one is taken
	assign load = !empty && (state == dist_types_pkg::EMIT_IDLE || i_opd_rdy);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			wp <= '0;
		else if (i_push)
			wp <= wp + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (i_push)
			mem[wp[dist_cfg_pkg::OPD_DEPTH_LOG2-1:0]] <= i_opd;
		if (load)
			out_data <= head.data;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			rp <= '0;
			out_wr <= '0;
			state <= dist_types_pkg::EMIT_IDLE;
		end
		else if (load)
		begin
			rp <= rp + 1'b1;
			out_wr <= head.mask;
			state <= dist_types_pkg::EMIT_BUSY;
		end
		else if (state == dist_types_pkg::EMIT_BUSY && i_opd_rdy)
		begin
			// taken and queue is empty
			out_wr <= '0;
			state <= dist_types_pkg::EMIT_IDLE;
		end
	end

	assign o_opd = '{data: out_data, wr: out_wr};

endmodule

`default_nettype wire

// File: rtl/opd_dispatcher.sv
/*
 * routes the head response and its channel mask to an operand queue,
 * holds the sticky error flush and forms the busy flag
 */
`timescale 1ns/1ps
`default_nettype none

module opd_dispatcher (
	input wire logic clk,
	input wire logic nrst,
	input wire logic i_err_flush,
	// response queue
	input wire dist_types_pkg::rsp_t i_rsp_head,
	input wire logic i_rsp_empty,
	input wire logic i_rsp_busy,
	output logic o_rsp_pop,
	// mask queues
	input wire dist_types_pkg::wmask_t [dist_cfg_pkg::NUM_CH-1:0] i_we_head,
	input wire logic [dist_cfg_pkg::NUM_CH-1:0] i_we_empty,
	input wire logic [dist_cfg_pkg::NUM_CH-1:0] i_we_busy,
	output logic [dist_cfg_pkg::NUM_CH-1:0] o_we_pop,
	// operand emitters
	input wire logic [dist_cfg_pkg::NUM_CH-1:0] i_opd_stall,
	input wire logic [dist_cfg_pkg::NUM_CH-1:0] i_opd_busy,
	output logic [dist_cfg_pkg::NUM_CH-1:0] o_push,
	output dist_types_pkg::opd_t o_push_opd,
	// control
	output logic o_flush,
	output logic o_busy
);

	dist_types_pkg::ch_idx_t sel;
	logic go;
	logic flush_q;
	logic rx_idle;

	// channel of the response at the queue head
	assign sel = {i_rsp_head.thread, i_rsp_head.arg};

	// response, mask and operand slot all present for that channel
	assign go = !i_rsp_empty && !i_we_empty[sel] && !i_opd_stall[sel] && !o_flush;

	assign o_rsp_pop = go;
	assign o_push_opd = '{data: i_rsp_head.data, mask: i_we_head[sel]};

	always_comb
	begin
		o_push = '0;
		o_we_pop = '0;
		if (go)
		begin
			o_push[sel] = 1'b1;
			o_we_pop[sel] = 1'b1;
		end
	end

	// nothing left on the receive side
	assign rx_idle = i_rsp_empty && !i_rsp_busy && (&i_we_empty) && !(|i_we_busy);

	assign o_flush = i_err_flush || flush_q;

	// sticky flush holds until the receive side has drained
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			flush_q <= 1'b0;
		else if (o_flush)
			flush_q <= !rx_idle;
	end

	assign o_busy = !rx_idle || (|i_opd_busy) || flush_q;

endmodule

`default_nettype wire

// File: rtl/we_receiver.sv
/*
 * word-enable mask receive FSM and mask queue for one channel
 */
`timescale 1ns/1ps
`default_nettype none

module we_receiver (
	input wire logic clk,
	input wire logic nrst,
	input wire dist_types_pkg::we_in_t i_we,
	output logic o_we_rd,
	input wire logic i_pop,
	input wire logic i_flush,
	output dist_types_pkg::wmask_t o_head,
	output logic o_empty,
	output logic o_busy
);

	dist_types_pkg::wmask_t mem [2**dist_cfg_pkg::WE_DEPTH_LOG2];

	logic [dist_cfg_pkg::WE_DEPTH_LOG2:0] wp;
	logic [dist_cfg_pkg::WE_DEPTH_LOG2:0] rp;
	logic [dist_cfg_pkg::WE_DEPTH_LOG2:0] used;
	logic stall;
	dist_types_pkg::rx_state_t state;

	assign used = wp - rp;
	assign stall = used[dist_cfg_pkg::WE_DEPTH_LOG2] ||
		(&used[dist_cfg_pkg::WE_DEPTH_LOG2-1:0]);

	assign o_empty = (wp == rp);
	assign o_busy = (state != dist_types_pkg::IDLE);
	assign o_head = mem[rp[dist_cfg_pkg::WE_DEPTH_LOG2-1:0]];

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wp <= '0;
			o_we_rd <= 1'b0;
			state <= dist_types_pkg::IDLE;
		end
		else
		begin
			case (state)
				dist_types_pkg::RECV:
				begin
					if (i_we.vld)
						wp <= wp + 1'b1;
					if (stall)
					begin
						o_we_rd <= 1'b0;
						state <= dist_types_pkg::STALL;
					end
					if (!i_we.vld)
					begin
						o_we_rd <= 1'b0;
						state <= dist_types_pkg::IDLE;
					end
				end
				dist_types_pkg::STALL:
				begin
					if (!stall)
					begin
						o_we_rd <= 1'b1;
						state <= dist_types_pkg::RECV;
					end
				end
				default:
				begin
					if (i_we.vld)
					begin
						o_we_rd <= 1'b1;
						state <= dist_types_pkg::RECV;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == dist_types_pkg::RECV && i_we.vld)
			mem[wp[dist_cfg_pkg::WE_DEPTH_LOG2-1:0]] <= i_we.mask;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			rp <= '0;
		else if (i_flush)
			rp <= wp;
		else if (i_pop)
			rp <= rp + 1'b1;
	end

endmodule

`default_nettype wire

// File: rtl/rsp_receiver.sv
/*
 * load/store response receive FSM and response queue
 */
`timescale 1ns/1ps
`default_nettype none

module rsp_receiver (
	input wire logic clk,
	input wire logic nrst,
	input wire logic i_rrs_vld,
	input wire dist_types_pkg::rsp_t i_rrs,
	output logic o_rrs_rd,
	input wire logic i_pop,
	input wire logic i_flush,
	output dist_types_pkg::rsp_t o_head,
	output logic o_empty,
	output logic o_busy
);

	dist_types_pkg::rsp_t mem [2**dist_cfg_pkg::RSP_DEPTH_LOG2];

	// pointers carry an extra wrap bit
	logic [dist_cfg_pkg::RSP_DEPTH_LOG2:0] wp;
	logic [dist_cfg_pkg::RSP_DEPTH_LOG2:0] rp;
	logic [dist_cfg_pkg::RSP_DEPTH_LOG2:0] used;
	logic stall;
	dist_types_pkg::rx_state_t state;

	assign used = wp - rp;

	// full or only one slot left
	assign stall = used[dist_cfg_pkg::RSP_DEPTH_LOG2] ||
		(&used[dist_cfg_pkg::RSP_DEPTH_LOG2-1:0]);

	assign o_empty = (wp == rp);
	assign o_busy = (state != dist_types_pkg::IDLE);
	assign o_head = mem[rp[dist_cfg_pkg::RSP_DEPTH_LOG2-1:0]];

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wp <= '0;
			o_rrs_rd <= 1'b0;
			state <= dist_types_pkg::IDLE;
		end
		else
		begin
			case (state)
				dist_types_pkg::RECV:
				begin
					if (i_rrs_vld)
						wp <= wp + 1'b1;
					if (stall)
					begin
						o_rrs_rd <= 1'b0;
						state <= dist_types_pkg::STALL;
					end
					// an idle source takes precedence over stall
					if (!i_rrs_vld)
					begin
						o_rrs_rd <= 1'b0;
						state <= dist_types_pkg::IDLE;
					end
				end
				dist_types_pkg::STALL:
				begin
					if (!stall)
					begin
						o_rrs_rd <= 1'b1;
						state <= dist_types_pkg::RECV;
					end
				end
				default:
				begin
					if (i_rrs_vld)
					begin
						o_rrs_rd <= 1'b1;
						state <= dist_types_pkg::RECV;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == dist_types_pkg::RECV && i_rrs_vld)
			mem[wp[dist_cfg_pkg::RSP_DEPTH_LOG2-1:0]] <= i_rrs;
	end

	// flush drops everything queued so far
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			rp <= '0;
		else if (i_flush)
			rp <= wp;
		else if (i_pop)
			rp <= rp + 1'b1;
	end

endmodule

`default_nettype wire

// File: rtl/dist_types_pkg.sv
/*
 * vector typedefs, port structs and FSM state enums
 * for the response distributor
 */
`default_nettype none

package dist_types_pkg;

	typedef logic [$clog2(dist_cfg_pkg::NUM_THREADS)-1:0] thread_t;

	// thread in the upper bits and argument in bit 0
	typedef logic [$clog2(dist_cfg_pkg::NUM_CH)-1:0] ch_idx_t;

	typedef logic [dist_cfg_pkg::DATA_W-1:0] data_t;
	typedef logic [dist_cfg_pkg::MASK_W-1:0] wmask_t;

	// load/store response
	typedef struct packed {
		thread_t thread;
		logic arg;
		data_t data;
	} rsp_t;

	// word-enable source for one channel
	typedef struct packed {
		wmask_t mask;
		logic vld;
	} we_in_t;

	// operand queue entry
	typedef struct packed {
		data_t data;
		wmask_t mask;
	} opd_t;

	// operand register file port
	typedef struct packed {
		data_t data;
		wmask_t wr;
	} opd_out_t;

	// receive FSM shared by response and mask receivers
	typedef enum logic [1:0] {
		IDLE,
		RECV,
		STALL
	} rx_state_t;

	typedef enum logic {
		EMIT_IDLE,
		EMIT_BUSY
	} emit_state_t;

endpackage

`default_nettype wire

// File: rtl/dist_cfg_pkg.sv
/*
 * sizing constants for the response distributor:
 * thread and argument counts, data and mask widths, queue depths
 */
`default_nettype none

package dist_cfg_pkg;

	// thread and argument space
	localparam int NUM_THREADS = 8;
	localparam int NUM_ARGS = 2;

	// one channel per thread and argument (Rs=0, Rt=1)
	localparam int NUM_CH = NUM_THREADS * NUM_ARGS;

	// response data and operand width
	localparam int DATA_W = 64;

	// one enable bit per 32-bit half of an operand
	localparam int MASK_W = 2;

	// queue depths as powers of two
	localparam int RSP_DEPTH_LOG2 = 3;
	localparam int WE_DEPTH_LOG2 = 2;
	localparam int OPD_DEPTH_LOG2 = 2;

endpackage

`default_nettype wire
